//--- sim.f
design/memOpsPkg.sv
design/vmemPkg.sv
design/tlbIf.sv
design/dataTlb.sv
design/tlbMissQueue.sv
design/addrGenUnit.sv
design/memStage.sv
dv/memStage_props.sv
dv/memStageChecker.sv
dv/memStageTb.sv

//--- run.sh
#!/bin/sh
# Build and run the memStage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module memStageTb -o memStageSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memStageSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^test passed$" sim.log; then
    exit 0
fi
exit 1

//--- dv/memStageTb.sv
`timescale 1ns/100ps

module memStageTb;
    import memOpsPkg::*;
    import vmemPkg::*;

    logic clk;
    logic rst;
    logic opValid;
    logic opReady;
    memOpcode opCode;
    logic [31:0] srcA;
    logic [31:0] srcB;
    sqNum opSqN;
    tagReg opTagDst;
    logic sv32En;
    privMode priv;
    logic flushValid;
    sqNum flushSqN;
    logic pwReqValid;
    logic pwReqReady;
    vpnT pwReqVpn;
    logic pwResValid;
    ppnT pwResPpn;
    pteRwx pwResRwx;
    logic pwResUser;
    logic pwResFault;
    logic memValid;
    logic [31:0] memAddr;
    logic [1:0] memSize;
    logic memSignExt;
    logic [3:0] memWmask;
    logic memIsStore;
    sqNum memSqN;
    tagReg memTagDst;
    logic resValid;
    sqNum resSqN;
    tagReg resTagDst;
    excFlags resFlags;
    logic [31:0] resTval;

    sqNum nextSq;
    logic walkStall;
    int walkCount;
    int tbErrors;
    int errBase;
    int testCount;
    int pageIdx;

    memStage #(
        .tlbEntries(4),
        .missQueueDepth(4)
    ) uut (.*);

    memStageChecker chk (.*);

    bind memStage memStageProps #(.missQueueDepth(missQueueDepth)) props (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Page-table walker model
    initial begin : walker
        vpnT vpn;
        int delay;
        forever begin
            @(posedge clk);
            if (!rst && pwReqValid && !walkStall) begin
                vpn = pwReqVpn;
                delay = $urandom_range(1, 6);
                @(negedge clk);
                pwReqReady = 1'b1;
                @(negedge clk);
                pwReqReady = 1'b0;
                walkCount++;
                repeat (delay - 1) @(negedge clk);
                pwResPpn = vpn ^ 20'h5A5A5;
                pwResFault = vpn[3:0] == 4'hF;
                pwResUser = vpn[4];
                pwResRwx = {1'b1, vpn[5], 1'b0};
                pwResValid = 1'b1;
                @(negedge clk);
                pwResValid = 1'b0;
            end
        end
    end

    function automatic memOpcode randCode();
        return memOpcode'($urandom_range(0, 7));
    endfunction

    function automatic memOpcode misCode();
        case ($urandom_range(0, 4))
            0: return opLh;
            1: return opLhu;
            2: return opLw;
            3: return opSh;
            default: return opSw;
        endcase
    endfunction

    function automatic logic [1:0] lowBits(memOpcode code, logic bad);
        case (code)
            opLb, opLbu, opSb: return 2'($urandom_range(0, 3));
            opLh, opLhu, opSh: return {1'($urandom_range(0, 1)), bad};
            default: return bad ? 2'($urandom_range(1, 3)) : 2'b00;
        endcase
    endfunction

    // Unique page built from an index, the writable and user bits and a low nibble
    function automatic vpnT makeVpn(logic w, logic u, logic [3:0] nib);
        pageIdx++;
        return {10'(pageIdx), 4'h0, w, u, nib};
    endfunction

    task automatic sendOp(memOpcode code, logic [31:0] a, logic [31:0] b);
        int waited;
        @(negedge clk);
        opValid = 1'b1;
        opCode = code;
        srcA = a;
        srcB = b;
        opSqN = nextSq;
        opTagDst = 6'($urandom_range(1, 63));
        waited = 0;
        while (!opReady && waited < 300) begin
            @(negedge clk);
            waited++;
        end
        if (!opReady) begin
            $display("timed out waiting for opReady on sqN %0d", nextSq);
            $display("test failed");
            $finish;
        end else begin
            @(posedge clk);
            nextSq++;
        end
    endtask

    task automatic sendBare(memOpcode code, logic bad);
        sendOp(code, $urandom & 32'hFFFF_FFFC, ($urandom & 32'hFFFF_FFFC) | lowBits(code, bad));
    endtask

    task automatic sendPaged(vpnT vpn, memOpcode code, logic bad);
        sendOp(code, {vpn, 12'h000}, {20'h0, 10'($urandom), lowBits(code, bad)});
    endtask

    task automatic drain();
        int waited;
        @(negedge clk);
        opValid = 1'b0;
        waited = 0;
        while (chk.pendingCount() != 0 && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (chk.pendingCount() != 0) begin
            chk.reportMissing();
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic endTest(string name);
        int total;
        total = chk.errors + tbErrors;
        $display("%-14s %0d errors", name, total - errBase);
        errBase = total;
        testCount++;
    endtask

    initial begin : main
        vpnT pg [3];
        vpnT fresh;
        sqNum firstSq;
        int base;
        int waited;
        void'($urandom(32'h6514));
        rst = 1'b1;
        opValid = 1'b0;
        opCode = opLw;
        srcA = '0;
        srcB = '0;
        opSqN = '0;
        opTagDst = '0;
        sv32En = 1'b0;
        priv = privSupervisor;
        flushValid = 1'b0;
        flushSqN = '0;
        pwReqReady = 1'b0;
        pwResValid = 1'b0;
        pwResPpn = '0;
        pwResRwx = '0;
        pwResUser = 1'b0;
        pwResFault = 1'b0;
        nextSq = '0;
        walkStall = 1'b0;
        walkCount = 0;
        tbErrors = 0;
        errBase = 0;
        testCount = 0;
        pageIdx = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Every opcode three times, at random addresses
        for (int i = 0; i < 24; i++) begin
            sendBare(memOpcode'(i % 8), 1'b0);
        end
        drain();
        endTest("bare");

        repeat (10) sendBare(misCode(), 1'b1);
        drain();
        sv32En = 1'b1;
        repeat (10) sendPaged(makeVpn(1'b1, 1'b0, 4'h1), misCode(), 1'b1);
        drain();
        endTest("misaligned");

        for (int i = 0; i < 3; i++) begin
            pg[i] = makeVpn(1'b1, 1'b0, 4'(i));
        end
        base = walkCount;
        for (int i = 0; i < 12; i++) begin
            sendPaged(pg[i % 3], randCode(), 1'b0);
        end
        drain();
        if (walkCount - base != 3) begin
            $display("expected 3 page walks for 3 pages, saw %0d", walkCount - base);
            tbErrors++;
        end
        endTest("translated");

        // Fault bit, read-only page, user page seen from supervisor
        pg[0] = makeVpn(1'b1, 1'b0, 4'hF);
        pg[1] = makeVpn(1'b0, 1'b0, 4'h1);
        pg[2] = makeVpn(1'b1, 1'b1, 4'h2);
        // Each page gets both loads and stores
        for (int i = 0; i < 12; i++) begin
            sendPaged(pg[i % 3], memOpcode'(i % 8), 1'b0);
        end
        drain();
        priv = privUser;
        pg[0] = makeVpn(1'b1, 1'b0, 4'h3);
        pg[1] = makeVpn(1'b1, 1'b1, 4'h4);
        for (int i = 0; i < 8; i++) begin
            sendPaged(pg[i % 2], memOpcode'(i), 1'b0);
        end
        drain();
        priv = privSupervisor;
        endTest("page faults");

        walkStall = 1'b1;
        firstSq = nextSq;
        sendPaged(makeVpn(1'b1, 1'b0, 4'h5), opLw, 1'b1);
        fresh = makeVpn(1'b1, 1'b0, 4'h6);
        repeat (3) sendPaged(fresh, randCode(), 1'b0);
        // New op in the flush cycle is younger and must vanish too
        @(negedge clk);
        flushValid = 1'b1;
        flushSqN = firstSq + 7'd1;
        opCode = opLw;
        srcA = {fresh, 12'h000};
        srcB = '0;
        opSqN = nextSq;
        nextSq++;
        @(negedge clk);
        flushValid = 1'b0;
        opValid = 1'b0;
        repeat (5) @(negedge clk);
        walkStall = 1'b0;
        drain();
        endTest("flush");

        walkStall = 1'b1;
        pg[0] = makeVpn(1'b1, 1'b0, 4'h7);
        pg[1] = makeVpn(1'b1, 1'b0, 4'h8);
        for (int i = 0; i < 4; i++) begin
            sendPaged(pg[i % 2], randCode(), 1'b0);
        end
        @(negedge clk);
        opValid = 1'b0;
        waited = 0;
        while (opReady && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (opReady) begin
            $display("opReady stayed high with a full miss queue");
            tbErrors++;
        end
        fork
            sendPaged(pg[0], randCode(), 1'b0);
            begin
                repeat (20) @(negedge clk);
                walkStall = 1'b0;
            end
        join
        drain();
        endTest("stalled walker");

        $display("%0d tests, %0d checks, %0d errors", testCount, chk.checks,
                 chk.errors + tbErrors);
        if (chk.errors + tbErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- dv/memStageChecker.sv
`timescale 1ns/100ps

module memStageChecker (
    input logic clk,
    input logic rst,
    input logic opValid,
    input logic opReady,
    input memOpsPkg::memOpcode opCode,
    input logic [31:0] srcA,
    input logic [31:0] srcB,
    input memOpsPkg::sqNum opSqN,
    input memOpsPkg::tagReg opTagDst,
    input logic sv32En,
    input vmemPkg::privMode priv,
    input logic flushValid,
    input memOpsPkg::sqNum flushSqN,
    input logic memValid,
    input logic [31:0] memAddr,
    input logic [1:0] memSize,
    input logic memSignExt,
    input logic [3:0] memWmask,
    input logic memIsStore,
    input memOpsPkg::sqNum memSqN,
    input memOpsPkg::tagReg memTagDst,
    input logic resValid,
    input memOpsPkg::sqNum resSqN,
    input memOpsPkg::tagReg resTagDst,
    input memOpsPkg::excFlags resFlags,
    input logic [31:0] resTval
);
    import memOpsPkg::*;
    import vmemPkg::*;

    typedef struct packed {
        logic wantMem;
        logic wantRes;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExt;
        logic [3:0] wmask;
        logic isStore;
        tagReg tag;
        excFlags flags;
        logic [31:0] tval;
    } expT;

    expT expTable [128];
    expT e;
    logic [127:0] pendMem = '0;
    logic [127:0] pendRes = '0;
    int errors = 0;
    int checks = 0;

    function automatic logic afterFlush(sqNum s, sqNum f);
        return $signed(7'(s - f)) > 0;
    endfunction

    // Expected outputs from the decode, fault and page-table rules
    function automatic expT refResult(memOpcode code, logic [31:0] a, logic [31:0] b,
                                      tagReg tag, logic sv32, privMode pm);
        expT r;
        logic [31:0] va;
        logic [19:0] vpn;
        logic mis;
        logic pf;
        r = '0;
        va = a + b;
        vpn = va[31:12];
        r.isStore = code inside {opSb, opSh, opSw};
        r.size = (code inside {opLb, opLbu, opSb}) ? 2'd0 :
                 (code inside {opLh, opLhu, opSh}) ? 2'd1 : 2'd2;
        r.signExt = code == opLb || code == opLh;
        if (r.isStore) begin
            r.wmask = (r.size == 2'd0) ? 4'b0001 << va[1:0] :
                      (r.size == 2'd1) ? 4'b0011 << {va[1], 1'b0} : 4'b1111;
        end
        r.tag = r.isStore ? tagZero : tag;
        mis = (r.size == 2'd1 && va[0]) || (r.size == 2'd2 && va[1:0] != 2'b00);
        pf = 1'b0;
        r.addr = va;
        if (sv32) begin
            r.addr = {vpn ^ 20'h5A5A5, va[11:0]};
            pf = vpn[3:0] == 4'hF || (r.isStore && !vpn[5]) || ((pm == privUser) != vpn[4]);
        end
        r.flags = mis ? (r.isStore ? flagsStMa : flagsLdMa) :
                  pf ? (r.isStore ? flagsStPf : flagsLdPf) : flagsNone;
        r.tval = va;
        r.wantMem = r.flags == flagsNone;
        r.wantRes = r.isStore || r.flags != flagsNone;
        return r;
    endfunction

    function automatic int pendingCount();
        return $countones(pendMem) + $countones(pendRes);
    endfunction

    task automatic reportMissing();
        for (int i = 0; i < 128; i++) begin
            if (pendMem[i]) begin
                $display("no memory op ever came out for sqN %0d", i);
                errors++;
            end
            if (pendRes[i]) begin
                $display("no result op ever came out for sqN %0d", i);
                errors++;
            end
        end
        pendMem = '0;
        pendRes = '0;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (memValid) begin
                checks++;
                e = expTable[memSqN];
                if (!pendMem[memSqN]) begin
                    $display("memory op for sqN %0d came out with nothing expected", memSqN);
                    errors++;
                end else if (memAddr !== e.addr || memSize !== e.size ||
                             memSignExt !== e.signExt || memWmask !== e.wmask ||
                             memIsStore !== e.isStore || memTagDst !== e.tag) begin
                    $display("FAILED %0t: sqN %0d mem op %h/%0d/%b/%b/%b/%0d, expected %h/%0d/%b/%b/%b/%0d",
                             $time, memSqN, memAddr, memSize, memSignExt, memWmask, memIsStore,
                             memTagDst, e.addr, e.size, e.signExt, e.wmask, e.isStore, e.tag);
                    errors++;
                end
                pendMem[memSqN] = 1'b0;
            end
            if (resValid) begin
                checks++;
                e = expTable[resSqN];
                if (!pendRes[resSqN]) begin
                    $display("result op for sqN %0d came out with nothing expected", resSqN);
                    errors++;
                end else if (resFlags !== e.flags || resTagDst !== e.tag ||
                             (e.flags != flagsNone && resTval !== e.tval)) begin
                    $display("FAILED %0t: sqN %0d result flags %0d tag %0d tval %h, expected %0d %0d %h",
                             $time, resSqN, resFlags, resTagDst, resTval, e.flags, e.tag, e.tval);
                    errors++;
                end
                pendRes[resSqN] = 1'b0;
            end
            // Outputs already issued are checked above, the flush only drops what is left
            if (flushValid) begin
                for (int i = 0; i < 128; i++) begin
                    if (afterFlush(7'(i), flushSqN)) begin
                        pendMem[i] = 1'b0;
                        pendRes[i] = 1'b0;
                    end
                end
            end
            if (opValid && opReady && !(flushValid && afterFlush(opSqN, flushSqN))) begin
                e = refResult(opCode, srcA, srcB, opTagDst, sv32En, priv);
                expTable[opSqN] = e;
                pendMem[opSqN] = e.wantMem;
                pendRes[opSqN] = e.wantRes;
            end
        end
    end

endmodule

//--- dv/memStage_props.sv
`timescale 1ns/100ps

module memStageProps #(
    parameter int missQueueDepth = 4
) (
    input logic clk,
    input logic rst,
    input logic memValid,
    input logic resValid,
    input logic pwReqValid,
    input logic pwReqReady,
    input vmemPkg::vpnT pwReqVpn,
    input logic [31:0] memAddr,
    input logic [1:0] memSize,
    input logic opReady,
    input logic enqueue,
    input memOpsPkg::aguOp enqueueOp,
    input logic dequeue,
    input memOpsPkg::aguOp queueOp,
    input logic flushValid,
    input memOpsPkg::sqNum flushSqN
);

    // Sequence numbers parked in the miss queue, one bit per sqN
    logic [127:0] queued;

    always_ff @(posedge clk) begin
        if (rst) begin
            queued <= '0;
        end else begin
            for (int i = 0; i < 128; i++) begin
                if (flushValid && $signed(7'(7'(i) - flushSqN)) > 0) begin
                    queued[i] <= 1'b0;
                end
            end
            if (dequeue) begin
                queued[queueOp.sqN] <= 1'b0;
            end
            if (enqueue) begin
                queued[enqueueOp.sqN] <= 1'b1;
            end
        end
    end

    quietAfterReset: assert property (@(posedge clk)
        rst |=> !memValid && !resValid && !pwReqValid)
        else $error("output valid during or right after reset");

    // Walk request must hold until the walker takes it
    walkReqHeld: assert property (@(posedge clk) disable iff (rst)
        pwReqValid && !pwReqReady |=> pwReqValid && $stable(pwReqVpn))
        else $error("walk request dropped or changed before pwReqReady");

    memAligned: assert property (@(posedge clk) disable iff (rst)
        memValid |-> !((memSize == 2'd1 && memAddr[0]) ||
                       (memSize == 2'd2 && memAddr[1:0] != 2'b00)))
        else $error("memory op issued with a misaligned address");

    fullQueueStalls: assert property (@(posedge clk) disable iff (rst)
        $countones(queued) == missQueueDepth |-> !opReady)
        else $error("opReady high while the miss queue is full");

endmodule

//--- design/memStage.sv
`timescale 1ns/100ps

module memStage #(
    parameter int tlbEntries = 4,
    parameter int missQueueDepth = 4
) (
    input logic clk,
    input logic rst,
    input logic opValid,
    output logic opReady,
    input memOpsPkg::memOpcode opCode,
    input memOpsPkg::memAddr srcA,
    input memOpsPkg::memAddr srcB,
    input memOpsPkg::sqNum opSqN,
    input memOpsPkg::tagReg opTagDst,
    input logic sv32En,
    input vmemPkg::privMode priv,
    input logic flushValid,
    input memOpsPkg::sqNum flushSqN,
    output logic pwReqValid,
    input logic pwReqReady,
    output vmemPkg::vpnT pwReqVpn,
    input logic pwResValid,
    input vmemPkg::ppnT pwResPpn,
    input vmemPkg::pteRwx pwResRwx,
    input logic pwResUser,
    input logic pwResFault,
    output logic memValid,
    output memOpsPkg::memAddr memAddr,
    output logic [1:0] memSize,
    output logic memSignExt,
    output logic [3:0] memWmask,
    output logic memIsStore,
    output memOpsPkg::sqNum memSqN,
    output memOpsPkg::tagReg memTagDst,
    output logic resValid,
    output memOpsPkg::sqNum resSqN,
    output memOpsPkg::tagReg resTagDst,
    output memOpsPkg::excFlags resFlags,
    output memOpsPkg::memAddr resTval
);
    import memOpsPkg::*;

    logic enqueue;
    aguOp enqueueOp;
    logic dequeue;
    aguOp queueOp;
    logic queueOpValid;
    logic [$clog2(missQueueDepth + 1) - 1:0] queueFree;
    logic walkDone;

    tlbIf tlbBus ();

    addrGenUnit #(
        .missQueueDepth(missQueueDepth)
    ) agu (
        .clk(clk),
        .rst(rst),
        .opValid(opValid),
        .opReady(opReady),
        .opCode(opCode),
        .srcA(srcA),
        .srcB(srcB),
        .opSqN(opSqN),
        .opTagDst(opTagDst),
        .sv32En(sv32En),
        .priv(priv),
        .flushValid(flushValid),
        .flushSqN(flushSqN),
        .pwReqValid(pwReqValid),
        .pwReqReady(pwReqReady),
        .pwReqVpn(pwReqVpn),
        .pwResValid(pwResValid),
        .pwResPpn(pwResPpn),
        .pwResRwx(pwResRwx),
        .pwResUser(pwResUser),
        .pwResFault(pwResFault),
        .memValid(memValid),
        .memAddr(memAddr),
        .memSize(memSize),
        .memSignExt(memSignExt),
        .memWmask(memWmask),
        .memIsStore(memIsStore),
        .memSqN(memSqN),
        .memTagDst(memTagDst),
        .resValid(resValid),
        .resSqN(resSqN),
        .resTagDst(resTagDst),
        .resFlags(resFlags),
        .resTval(resTval),
        .enqueue(enqueue),
        .enqueueOp(enqueueOp),
        .dequeue(dequeue),
        .queueOp(queueOp),
        .queueOpValid(queueOpValid),
        .queueFree(queueFree),
        .walkDone(walkDone),
        .tlbLookup(tlbBus.agu),
        .tlbFill(tlbBus.walk)
    );

    dataTlb #(
        .tlbEntries(tlbEntries)
    ) dtlb (
        .clk(clk),
        .rst(rst),
        .tlb(tlbBus.tlb)
    );

    tlbMissQueue #(
        .missQueueDepth(missQueueDepth)
    ) missQueue (
        .clk(clk),
        .rst(rst),
        .enqueue(enqueue),
        .enqueueOp(enqueueOp),
        .dequeue(dequeue),
        .queueOp(queueOp),
        .queueOpValid(queueOpValid),
        .queueFree(queueFree),
        .walkDone(walkDone),
        .flushValid(flushValid),
        .flushSqN(flushSqN)
    );

endmodule

//--- design/addrGenUnit.sv
`timescale 1ns/100ps

module addrGenUnit #(
    parameter int missQueueDepth = 4
) (
    input logic clk,
    input logic rst,
    input logic opValid,
    output logic opReady,
    input memOpsPkg::memOpcode opCode,
    input memOpsPkg::memAddr srcA,
    input memOpsPkg::memAddr srcB,
    input memOpsPkg::sqNum opSqN,
    input memOpsPkg::tagReg opTagDst,
    input logic sv32En,
    input vmemPkg::privMode priv,
    input logic flushValid,
    input memOpsPkg::sqNum flushSqN,
    output logic pwReqValid,
    input logic pwReqReady,
    output vmemPkg::vpnT pwReqVpn,
    input logic pwResValid,
    input vmemPkg::ppnT pwResPpn,
    input vmemPkg::pteRwx pwResRwx,
    input logic pwResUser,
    input logic pwResFault,
    output logic memValid,
    output memOpsPkg::memAddr memAddr,
    output logic [1:0] memSize,
    output logic memSignExt,
    output logic [3:0] memWmask,
    output logic memIsStore,
    output memOpsPkg::sqNum memSqN,
    output memOpsPkg::tagReg memTagDst,
    output logic resValid,
    output memOpsPkg::sqNum resSqN,
    output memOpsPkg::tagReg resTagDst,
    output memOpsPkg::excFlags resFlags,
    output memOpsPkg::memAddr resTval,
    output logic enqueue,
    output memOpsPkg::aguOp enqueueOp,
    output logic dequeue,
    input memOpsPkg::aguOp queueOp,
    input logic queueOpValid,
    input logic [$clog2(missQueueDepth + 1) - 1:0] queueFree,
    output logic walkDone,
    tlbIf.agu tlbLookup,
    tlbIf.walk tlbFill
);
    import memOpsPkg::*;
    import vmemPkg::*;

    typedef enum logic [1:0] {walkIdle, walkReq, walkWait} walkState;

    walkState walkSt;
    vpnT walkVpn;
    aguOp newOp;
    aguOp selOp;
    logic selKeep;
    logic misaligned;
    logic permFault;
    logic tlbMiss;
    logic issue;
    excFlags flags;

    assign opReady = queueFree != '0;

    always_comb begin
        newOp = '0;
        newOp.valid = opValid && opReady;
        newOp.addr = srcA + srcB;
        newOp.sqN = opSqN;
        newOp.tagDst = opTagDst;
        newOp.isLoad = opCode inside {opLb, opLh, opLw, opLbu, opLhu};
        newOp.isStore = !newOp.isLoad;
        case (opCode)
            opLb, opLbu: begin
                newOp.size = 2'd0;
                newOp.signExt = opCode == opLb;
            end
            opLh, opLhu: begin
                newOp.size = 2'd1;
                newOp.signExt = opCode == opLh;
            end
            opLw: begin
                newOp.size = 2'd2;
            end
            opSb: begin
                newOp.size = 2'd0;
                newOp.wmask = 4'b0001 << newOp.addr[1:0];
            end
            opSh: begin
                newOp.size = 2'd1;
                newOp.wmask = newOp.addr[1] ? 4'b1100 : 4'b0011;
            end
            opSw: begin
                newOp.size = 2'd2;
                newOp.wmask = 4'b1111;
            end
        endcase
        // Stores write no register
        if (newOp.isStore) begin
            newOp.tagDst = tagZero;
        end
    end

    // New op first, then a replay from the miss queue
    always_comb begin
        selOp = '0;
        dequeue = 1'b0;
        if (newOp.valid) begin
            selOp = newOp;
        end else if (queueOpValid) begin
            selOp = queueOp;
            dequeue = 1'b1;
        end
    end

    assign selKeep = selOp.valid && !(flushValid && isYounger(selOp.sqN, flushSqN));

    assign tlbLookup.lookupValid = selOp.valid && sv32En;
    assign tlbLookup.lookupVpn = selOp.addr[31:12];

    assign misaligned = (selOp.size == 2'd1 && selOp.addr[0]) ||
                        (selOp.size == 2'd2 && selOp.addr[1:0] != 2'b00);

    assign permFault = (selOp.isLoad && !tlbLookup.rwx[rwxRead]) ||
                       (selOp.isStore && !tlbLookup.rwx[rwxWrite]) ||
                       (priv == privUser && !tlbLookup.user) ||
                       (priv == privSupervisor && tlbLookup.user);

    always_comb begin
        flags = flagsNone;
        if (sv32En && tlbLookup.hit && (tlbLookup.pageFault || permFault)) begin
            flags = selOp.isStore ? flagsStPf : flagsLdPf;
        end
        // Misalignment wins over page faults
        if (misaligned) begin
            flags = selOp.isStore ? flagsStMa : flagsLdMa;
        end
    end

    assign tlbMiss = sv32En && !tlbLookup.hit && !misaligned;
    assign enqueue = selKeep && tlbMiss;
    assign enqueueOp = selOp;
    assign issue = selKeep && !tlbMiss;

    assign pwReqValid = walkSt == walkReq;
    assign pwReqVpn = walkVpn;
    assign walkDone = pwResValid && walkSt == walkWait;

    assign tlbFill.fillValid = walkDone;
    assign tlbFill.fillVpn = walkVpn;
    assign tlbFill.fillPpn = pwResPpn;
    assign tlbFill.fillRwx = pwResRwx;
    assign tlbFill.fillUser = pwResUser;
    assign tlbFill.fillFault = pwResFault;

    always_ff @(posedge clk) begin
        if (rst) begin
            walkSt <= walkIdle;
        end else begin
            case (walkSt)
                walkIdle: begin
                    if (enqueue) begin
                        walkSt <= walkReq;
                    end
                end
                walkReq: begin
                    if (pwReqReady) begin
                        walkSt <= walkWait;
                    end
                end
                walkWait: begin
                    if (pwResValid) begin
                        walkSt <= walkIdle;
                    end
                end
                default: begin
                    walkSt <= walkIdle;
                end
            endcase
        end
        if (walkSt == walkIdle && enqueue) begin
            walkVpn <= selOp.addr[31:12];
        end
    end

    // Stores go to both channels, faulting ops only to the result channel
    always_ff @(posedge clk) begin
        if (rst) begin
            memValid <= 1'b0;
            resValid <= 1'b0;
        end else begin
            memValid <= issue && flags == flagsNone;
            resValid <= issue && (selOp.isStore || flags != flagsNone);
        end
    end

    always_ff @(posedge clk) begin
        memAddr <= sv32En ? {tlbLookup.ppn, selOp.addr[11:0]} : selOp.addr;
        memSize <= selOp.size;
        memSignExt <= selOp.signExt;
        memWmask <= selOp.wmask;
        memIsStore <= selOp.isStore;
        memSqN <= selOp.sqN;
        memTagDst <= selOp.tagDst;
        resSqN <= selOp.sqN;
        resTagDst <= selOp.tagDst;
        resFlags <= flags;
        resTval <= selOp.addr;
    end

endmodule

//--- design/tlbMissQueue.sv
`timescale 1ns/100ps

module tlbMissQueue #(
    parameter int missQueueDepth = 4
) (
    input logic clk,
    input logic rst,
    input logic enqueue,
    input memOpsPkg::aguOp enqueueOp,
    input logic dequeue,
    output memOpsPkg::aguOp queueOp,
    output logic queueOpValid,
    output logic [$clog2(missQueueDepth + 1) - 1:0] queueFree,
    input logic walkDone,
    input logic flushValid,
    input memOpsPkg::sqNum flushSqN
);
    import memOpsPkg::*;

    localparam int idxW = (missQueueDepth > 1) ? $clog2(missQueueDepth) : 1;

    // The op's own valid bit marks an occupied slot
    aguOp entries [missQueueDepth];
    logic [missQueueDepth-1:0] entReady;
    logic [idxW-1:0] selIdx;
    logic [idxW-1:0] freeIdx;

    // Oldest ready entry
    always_comb begin
        queueOpValid = 1'b0;
        selIdx = '0;
        for (int i = 0; i < missQueueDepth; i++) begin
            if (entries[i].valid && entReady[i] &&
                (!queueOpValid || isYounger(entries[selIdx].sqN, entries[i].sqN))) begin
                queueOpValid = 1'b1;
                selIdx = idxW'(i);
            end
        end
        queueOp = entries[selIdx];
        queueOp.valid = queueOpValid;
    end

    // A replayed op that misses again may take back its own slot
    always_comb begin
        freeIdx = '0;
        queueFree = '0;
        for (int i = missQueueDepth - 1; i >= 0; i--) begin
            if (!entries[i].valid || (dequeue && selIdx == idxW'(i))) begin
                freeIdx = idxW'(i);
            end
            if (!entries[i].valid) begin
                queueFree = queueFree + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < missQueueDepth; i++) begin
                entries[i].valid <= 1'b0;
            end
            entReady <= '0;
        end else begin
            for (int i = 0; i < missQueueDepth; i++) begin
                if (walkDone) begin
                    entReady[i] <= 1'b1;
                end
                if (flushValid && isYounger(entries[i].sqN, flushSqN)) begin
                    entries[i].valid <= 1'b0;
                end
            end
            if (dequeue) begin
                entries[selIdx].valid <= 1'b0;
            end
            // Enqueued in the walk-done cycle, so the fresh fill may already cover it
            if (enqueue) begin
                entries[freeIdx] <= enqueueOp;
                entReady[freeIdx] <= walkDone;
            end
        end
    end

endmodule

//--- design/dataTlb.sv
`timescale 1ns/100ps

module dataTlb #(
    parameter int tlbEntries = 4
) (
    input logic clk,
    input logic rst,
    tlbIf.tlb tlb
);
    import vmemPkg::*;

    localparam int idxW = (tlbEntries > 1) ? $clog2(tlbEntries) : 1;

    typedef struct packed {
        vpnT vpn;
        ppnT ppn;
        pteRwx rwx;
        logic user;
        logic fault;
    } tlbEntry;

    tlbEntry entries [tlbEntries];
    logic [tlbEntries-1:0] entValid;
    logic [idxW-1:0] rrPtr;
    logic [idxW-1:0] wrIdx;
    logic fillHit;

    always_comb begin
        tlb.hit = 1'b0;
        tlb.ppn = '0;
        tlb.rwx = '0;
        tlb.user = 1'b0;
        tlb.pageFault = 1'b0;
        for (int i = 0; i < tlbEntries; i++) begin
            if (tlb.lookupValid && entValid[i] && entries[i].vpn == tlb.lookupVpn) begin
                tlb.hit = 1'b1;
                tlb.ppn = entries[i].ppn;
                tlb.rwx = entries[i].rwx;
                tlb.user = entries[i].user;
                tlb.pageFault = entries[i].fault;
            end
        end
    end

    // Refill of a page already present overwrites it in place
    always_comb begin
        fillHit = 1'b0;
        wrIdx = rrPtr;
        for (int i = 0; i < tlbEntries; i++) begin
            if (entValid[i] && entries[i].vpn == tlb.fillVpn) begin
                fillHit = 1'b1;
                wrIdx = idxW'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            rrPtr <= '0;
        end else if (tlb.fillValid) begin
            entValid[wrIdx] <= 1'b1;
            if (!fillHit) begin
                rrPtr <= (rrPtr == idxW'(tlbEntries - 1)) ? '0 : rrPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb.fillValid) begin
            entries[wrIdx] <= '{tlb.fillVpn, tlb.fillPpn, tlb.fillRwx, tlb.fillUser,
                                tlb.fillFault};
        end
    end

endmodule

//--- design/tlbIf.sv
`timescale 1ns/100ps

interface tlbIf;
    import vmemPkg::*;

    logic lookupValid;
    vpnT lookupVpn;
    logic hit;
    ppnT ppn;
    pteRwx rwx;
    logic user;
    logic pageFault;

    // Walk result written into the TLB
    logic fillValid;
    vpnT fillVpn;
    ppnT fillPpn;
    pteRwx fillRwx;
    logic fillUser;
    logic fillFault;

    modport agu (
        output lookupValid, lookupVpn,
        input hit, ppn, rwx, user, pageFault
    );

    modport walk (
        output fillValid, fillVpn, fillPpn, fillRwx, fillUser, fillFault
    );

    modport tlb (
        input lookupValid, lookupVpn,
        input fillValid, fillVpn, fillPpn, fillRwx, fillUser, fillFault,
        output hit, ppn, rwx, user, pageFault
    );

endinterface

//--- design/vmemPkg.sv
package vmemPkg;

    typedef logic [19:0] vpnT;

    // Sv32 physical page number cut down to a 32-bit physical space
    typedef logic [19:0] ppnT;

    typedef enum logic {
        privUser = 1'b0,
        privSupervisor = 1'b1
    } privMode;

    // Read, write, execute
    typedef logic [2:0] pteRwx;

    localparam int rwxRead = 2;
    localparam int rwxWrite = 1;

endpackage

//--- design/memOpsPkg.sv
package memOpsPkg;

    typedef logic [6:0] sqNum;
    typedef logic [5:0] tagReg;
    typedef logic [31:0] memAddr;

    // Destination tag of ops that write no register
    localparam tagReg tagZero = '0;

    typedef enum logic [2:0] {
        opLb,
        opLh,
        opLw,
        opLbu,
        opLhu,
        opSb,
        opSh,
        opSw
    } memOpcode;

    typedef enum logic [2:0] {
        flagsNone,
        flagsLdMa,
        flagsStMa,
        flagsLdPf,
        flagsStPf
    } excFlags;

    typedef struct packed {
        logic valid;
        memAddr addr;
        logic [1:0] size;
        logic signExt;
        logic [3:0] wmask;
        logic isLoad;
        logic isStore;
        sqNum sqN;
        tagReg tagDst;
    } aguOp;

    // True when a comes after b in program order, sequence numbers wrap
    function automatic logic isYounger(sqNum a, sqNum b);
        return $signed(sqNum'(a - b)) > 0;
    endfunction

endpackage
